// ==== run_sim.sh ====
#!/bin/sh
# build and run the vidctl testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vidctl.f --top-module vidctl_tb -o vidctl_sim

./obj_dir/vidctl_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== source/bus_regs.sv ====
`timescale 1ns/1ps
`include "vidctl_defs.svh"

module bus_regs import vidctl_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,       // one access per low cycle
    input  logic       bus_rd_nwr_i,     // 1 read, 0 write
    input  logic [1:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,    // 0 even (high) byte, 1 odd (low) byte
    input  bus_byte_t  bus_data_i,
    input  logic       blit_cycle_i,     // vram free for us this cycle
    input  logic       vblank_i,
    output bus_byte_t  bus_data_o,       // read data, one cycle after access
    output logic       vram_wr_o,
    output vram_addr_t vram_addr_o,
    output vram_word_t vram_data_o,
    output logic       pal_wr_o,
    output pal_index_t pal_wr_index_o,
    output color_t     pal_wr_color_o
);

    bus_byte_t  hi_byte_q;               // even byte waiting for its partner
    vram_addr_t addr_q;                  // ADDR register
    vram_addr_t pend_addr_q;             // target of queued vram write
    vram_word_t pend_word_q;             // queued vram word or palette entry
    wr_state_t  state_q;
    wr_state_t  state_d;
    vram_word_t wr_word;
    vram_word_t addr_word;
    logic       wr_access;
    logic       rd_access;
    logic       wr_done;
    logic       busy;

    assign wr_access = ~bus_cs_n_i & ~bus_rd_nwr_i;
    assign rd_access = ~bus_cs_n_i & bus_rd_nwr_i;
    assign wr_done   = wr_access & bus_bytesel_i;       // odd byte completes the word
    assign wr_word   = {hi_byte_q, bus_data_i};
    assign addr_word = vram_word_t'(addr_q);            // zero extended for readback
    assign busy      = (state_q != IDLE);

    always_ff @(posedge clk) begin
        if (wr_access && !bus_bytesel_i) begin
            hi_byte_q <= bus_data_i;
        end
    end

    // address register, data writes bump it only when accepted
    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_q <= '0;
        end else if (wr_done) begin
            if (bus_reg_num_i == `REG_ADDR) begin
                addr_q <= wr_word[`VRAM_ADDR_W-1:0];
            end else if (bus_reg_num_i == `REG_DATA && !busy) begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_done && !busy) begin      // busy completions are dropped
            pend_word_q <= wr_word;
            pend_addr_q <= addr_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (wr_done && bus_reg_num_i == `REG_DATA) begin
                    state_d = PEND_VRAM;
                end else if (wr_done && bus_reg_num_i == `REG_PALETTE) begin
                    state_d = PEND_PAL;
                end
            end
            PEND_VRAM: begin
                if (blit_cycle_i) begin  // write goes out now
                    state_d = IDLE;
                end
            end
            PEND_PAL: state_d = IDLE;    // palette port never blocked
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_data_o <= '0;
        end else if (rd_access) begin
            case (bus_reg_num_i)
                `REG_ADDR:   bus_data_o <= bus_bytesel_i ? addr_word[7:0] : addr_word[15:8];
                `REG_STATUS: bus_data_o <= {6'b0, vblank_i, busy};
                default:     bus_data_o <= '0;
            endcase
        end
    end

    assign vram_wr_o      = (state_q == PEND_VRAM) & blit_cycle_i;  // one cycle strobe
    assign vram_addr_o    = pend_addr_q;
    assign vram_data_o    = pend_word_q;
    assign pal_wr_o       = (state_q == PEND_PAL);
    assign pal_wr_index_o = pend_word_q[15:12];
    assign pal_wr_color_o = pend_word_q[11:0];

endmodule

// ==== source/palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram import vidctl_pkg::*; (
    input  logic       clk,
    input  pal_index_t rd_index_i,       // pixel index from video_gen
    input  logic       wr_en_i,
    input  pal_index_t wr_index_i,
    input  color_t     wr_color_i,
    output color_t     rd_color_o        // one cycle after rd_index_i
);

    color_t pal_mem [16] = '{default: '0};   // all entries black at start

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            pal_mem[wr_index_i] <= wr_color_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_color_o <= pal_mem[rd_index_i];   // registered lookup
    end

endmodule

// ==== source/vidctl_defs.svh ====
`ifndef VIDCTL_DEFS_SVH
`define VIDCTL_DEFS_SVH

// horizontal raster, in pixel clocks
`define VID_H_VISIBLE 16
`define VID_H_FRONT   2
`define VID_H_SYNC    3
`define VID_H_BACK    3              // 24 clocks per line

// vertical raster, in lines
`define VID_V_VISIBLE 8
`define VID_V_FRONT   1
`define VID_V_SYNC    2
`define VID_V_BACK    1              // 12 lines per frame

// vram word address width
`define VRAM_ADDR_W   12

// host register numbers
`define REG_ADDR      2'd0           // vram address, auto-increments on data
`define REG_DATA      2'd1           // vram write data
`define REG_PALETTE   2'd2           // index in 15..12, color in 11..0
`define REG_STATUS    2'd3           // bit 0 busy, bit 1 vblank

`endif

// ==== source/vidctl_main.sv ====
`timescale 1ns/1ps

module vidctl_main import vidctl_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,       // access strobe, active low
    input  logic       bus_rd_nwr_i,     // 1 read, 0 write
    input  logic [1:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,    // 0 even byte, 1 odd byte
    input  bus_byte_t  bus_data_i,
    output bus_byte_t  bus_data_o,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,          // active low
    output logic       vsync_o,          // active low
    output logic       dv_de_o
);

    logic       blit_cycle;              // bus owns vram this cycle
    logic       vblank;
    logic       bus_vram_wr;
    vram_addr_t bus_vram_addr;
    vram_word_t bus_vram_data;
    vram_addr_t vgen_addr;
    vram_addr_t vram_addr;
    logic       vram_wr;
    vram_word_t vram_rdata;
    logic       pal_wr;
    pal_index_t pal_wr_index;
    color_t     pal_wr_color;
    pal_index_t pal_index;
    color_t     pal_color;
    logic       vgen_hsync;              // pixel pipe stage 2
    logic       vgen_vsync;
    logic       vgen_de;
    logic       hsync_d;                 // stage 3, matches palette read
    logic       vsync_d;
    logic       de_d;

    bus_regs u_bus_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .blit_cycle_i   (blit_cycle),
        .vblank_i       (vblank),
        .bus_data_o     (bus_data_o),
        .vram_wr_o      (bus_vram_wr),
        .vram_addr_o    (bus_vram_addr),
        .vram_data_o    (bus_vram_data),
        .pal_wr_o       (pal_wr),
        .pal_wr_index_o (pal_wr_index),
        .pal_wr_color_o (pal_wr_color)
    );

    video_gen u_video_gen (
        .clk          (clk),
        .reset_i      (reset_i),
        .vram_data_i  (vram_rdata),
        .blit_cycle_o (blit_cycle),
        .vram_addr_o  (vgen_addr),
        .pal_index_o  (pal_index),
        .hsync_o      (vgen_hsync),
        .vsync_o      (vgen_vsync),
        .dv_de_o      (vgen_de),
        .vblank_o     (vblank)
    );

    // video fetches on its own cycle, bus gets the rest
    assign vram_addr = blit_cycle ? bus_vram_addr : vgen_addr;
    assign vram_wr   = blit_cycle & bus_vram_wr;

    vram u_vram (
        .clk     (clk),
        .wr_en_i (vram_wr),
        .addr_i  (vram_addr),
        .data_i  (bus_vram_data),
        .data_o  (vram_rdata)
    );

    palette_ram u_palette_ram (
        .clk        (clk),
        .rd_index_i (pal_index),
        .wr_en_i    (pal_wr),
        .wr_index_i (pal_wr_index),
        .wr_color_i (pal_wr_color),
        .rd_color_o (pal_color)
    );

    // delay syncs one stage for the palette lookup
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            de_d    <= 1'b0;
        end else begin
            hsync_d <= vgen_hsync;
            vsync_d <= vgen_vsync;
            de_d    <= vgen_de;
        end
    end

    // output register, black outside the display area
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            dv_de_o <= 1'b0;
            red_o   <= 4'h0;
            green_o <= 4'h0;
            blue_o  <= 4'h0;
        end else begin
            hsync_o <= hsync_d;
            vsync_o <= vsync_d;
            dv_de_o <= de_d;
            red_o   <= de_d ? pal_color[11:8] : 4'h0;
            green_o <= de_d ? pal_color[7:4]  : 4'h0;
            blue_o  <= de_d ? pal_color[3:0]  : 4'h0;
        end
    end

endmodule

// ==== source/vidctl_pkg.sv ====
`include "vidctl_defs.svh"

package vidctl_pkg;

    // vram word address
    typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;

    // vram data, four 4-bit pixels, pixel 0 in the top nibble
    typedef logic [15:0] vram_word_t;

    typedef logic [3:0] pal_index_t;     // palette entry number

    // rgb color, red 11..8, green 7..4, blue 3..0
    typedef logic [11:0] color_t;

    typedef logic [7:0] bus_byte_t;      // host bus byte

    // pending write state of the bus block
    typedef enum logic [1:0] {
        IDLE,                            // nothing queued
        PEND_VRAM,                       // vram write waits for blit cycle
        PEND_PAL                         // palette write, goes out next cycle
    } wr_state_t;

endpackage

// ==== source/video_gen.sv ====
`timescale 1ns/1ps
`include "vidctl_defs.svh"

module video_gen import vidctl_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  vram_word_t vram_data_i,      // read data, one cycle after address
    output logic       blit_cycle_o,     // vram not needed for video
    output vram_addr_t vram_addr_o,
    output pal_index_t pal_index_o,
    output logic       hsync_o,          // active low
    output logic       vsync_o,          // active low
    output logic       dv_de_o,
    output logic       vblank_o
);

    localparam int H_TOTAL = `VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
    localparam int V_TOTAL = `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);
    localparam int WORDS_PER_LINE = `VID_H_VISIBLE / 4;    // four pixels per word

    localparam logic [H_W-1:0] H_LAST   = H_W'(H_TOTAL - 1);
    localparam logic [H_W-1:0] H_VIS    = H_W'(`VID_H_VISIBLE);
    localparam logic [H_W-1:0] HS_START = H_W'(`VID_H_VISIBLE + `VID_H_FRONT);
    localparam logic [H_W-1:0] HS_END   = H_W'(`VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC);
    localparam logic [V_W-1:0] V_LAST   = V_W'(V_TOTAL - 1);
    localparam logic [V_W-1:0] V_VIS    = V_W'(`VID_V_VISIBLE);
    localparam logic [V_W-1:0] VS_START = V_W'(`VID_V_VISIBLE + `VID_V_FRONT);
    localparam logic [V_W-1:0] VS_END   = V_W'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           visible;
    logic           hs_act;
    logic           vs_act;
    logic           fetch;
    logic           fetch_d1;            // vram data valid this cycle
    logic           hs_d1;
    logic           vs_d1;
    logic           de_d1;
    vram_word_t     word_q;              // pixel shifter

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign visible = (h_cnt < H_VIS) && (v_cnt < V_VIS);
    assign hs_act  = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vs_act  = (v_cnt >= VS_START) && (v_cnt < VS_END);   // whole lines
    assign fetch   = visible && (h_cnt[1:0] == 2'b00);          // pixel phase 0

    assign blit_cycle_o = ~fetch;
    assign vblank_o     = (v_cnt >= V_VIS);
    // line y starts at word y * 4, x / 4 within the line
    assign vram_addr_o  = vram_addr_t'(v_cnt) * vram_addr_t'(WORDS_PER_LINE)
                        + vram_addr_t'(h_cnt >> 2);

    // stage 1, vram read in flight
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_d1 <= 1'b0;
            hs_d1    <= 1'b0;
            vs_d1    <= 1'b0;
            de_d1    <= 1'b0;
        end else begin
            fetch_d1 <= fetch;
            hs_d1    <= hs_act;
            vs_d1    <= vs_act;
            de_d1    <= visible;
        end
    end

    // stage 2, syncs and enable line up with pal_index_o
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            dv_de_o <= 1'b0;
        end else begin
            hsync_o <= ~hs_d1;
            vsync_o <= ~vs_d1;
            dv_de_o <= de_d1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_d1) begin
            word_q <= vram_data_i;               // load fresh word
        end else begin
            word_q <= {word_q[11:0], 4'h0};      // next nibble to the top
        end
    end

    assign pal_index_o = word_q[15:12];

endmodule

// ==== source/vram.sv ====
`timescale 1ns/1ps
`include "vidctl_defs.svh"

module vram import vidctl_pkg::*; (
    input  logic       clk,
    input  logic       wr_en_i,
    input  vram_addr_t addr_i,           // shared read/write address
    input  vram_word_t data_i,
    output vram_word_t data_o            // valid the cycle after addr_i
);

    localparam int DEPTH = 1 << `VRAM_ADDR_W;

    vram_word_t mem [DEPTH];

    // single port, read always on, old data on a write cycle
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[addr_i] <= data_i;
        end
        data_o <= mem[addr_i];
    end

endmodule

// ==== verif/vidctl_tb.sv ====
`timescale 1ns/1ps
`include "vidctl_defs.svh"

module vidctl_tb;

    localparam int H_TOTAL = `VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
    localparam int V_TOTAL = `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
    localparam int H_VIS = `VID_H_VISIBLE;
    localparam int V_VIS = `VID_V_VISIBLE;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int NUM_WRITES = 16 + 32 + 8 + 2;        // palette, load, rewrite, addr
    localparam int WRITE_CYCLES = 12;                   // generous, with busy polling
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + NUM_WRITES * WRITE_CYCLES;
    localparam logic [31:0] SEED = 32'hf371_2a86;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        cs_n;
    logic        rd_nwr;
    logic [1:0]  reg_sel;
    logic        byte_sel;
    logic [7:0]  wr_byte;
    logic [7:0]  rd_byte;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [11:0] rgb;

    logic [15:0] fb_model [1 << `VRAM_ADDR_W];          // expected vram contents
    logic [11:0] pal_model [16];
    logic [`VRAM_ADDR_W-1:0] addr_model;
    logic [31:0] rnd;
    logic [11:0] exp_rgb;
    logic        pix_check_en = 1'b0;                   // set for frames under test
    logic        seen_de = 1'b0;
    logic        hs_prev = 1'b1;
    logic        vs_prev = 1'b1;
    logic        de_prev = 1'b0;
    logic        hs_seen = 1'b0;
    logic        vs_seen = 1'b0;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    int          px = 0;
    int          py = 0;
    int          pix_checked = 0;
    int          hs_low = 0;
    int          hs_gap = 0;
    int          vs_low = 0;
    int          vs_gap = 0;
    int          de_len = 0;
    int          de_runs = 0;
    int          raster_frames = 0;

    vidctl_main u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (cs_n),
        .bus_rd_nwr_i  (rd_nwr),
        .bus_reg_num_i (reg_sel),
        .bus_bytesel_i (byte_sel),
        .bus_data_i    (wr_byte),
        .bus_data_o    (rd_byte),
        .red_o         (red),
        .green_o       (green),
        .blue_o        (blue),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .dv_de_o       (de)
    );

    assign rgb = {red, green, blue};

    always #20 clk = ~clk;                              // 40 ns period

    task automatic report_mismatch(input string sig, input int expv, input int actv);
        $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, sig, expv, actv);
        err_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s", msg);
        err_cnt++;
    endtask

    // palette entry for pixel (x, y), pixel 0 in the top nibble
    function automatic logic [11:0] expected_color(input int x, input int y);
        logic [15:0] word;
        logic [3:0]  idx;
        word = fb_model[`VRAM_ADDR_W'(y * (H_VIS / 4) + x / 4)];
        idx  = 4'(word >> (12 - 4 * (x % 4)));
        return pal_model[idx];
    endfunction

    // all bus tasks start and end right after a falling edge
    task automatic write_byte(input logic [1:0] num, input logic sel, input logic [7:0] value);
        cs_n     = 1'b0;
        rd_nwr   = 1'b0;
        reg_sel  = num;
        byte_sel = sel;
        wr_byte  = value;
        @(negedge clk);
        cs_n     = 1'b1;
    endtask

    task automatic read_reg(input logic [1:0] num, input logic sel, output logic [7:0] value);
        cs_n     = 1'b0;
        rd_nwr   = 1'b1;
        reg_sel  = num;
        byte_sel = sel;
        @(negedge clk);
        cs_n     = 1'b1;
        value    = rd_byte;                             // registered the cycle before
    endtask

    task automatic write_word(input logic [1:0] num, input logic [15:0] value);
        write_byte(num, 1'b0, value[15:8]);             // high byte latched
        write_byte(num, 1'b1, value[7:0]);              // completes the word
    endtask

    task automatic wait_not_busy();
        logic [7:0] st;
        read_reg(`REG_STATUS, 1'b0, st);
        while (st[0]) begin
            read_reg(`REG_STATUS, 1'b0, st);
        end
    endtask

    task automatic set_addr(input logic [15:0] value);
        write_word(`REG_ADDR, value);
        addr_model = value[`VRAM_ADDR_W-1:0];
    endtask

    task automatic data_write(input logic [15:0] word);
        logic [7:0] st;
        wait_not_busy();
        write_word(`REG_DATA, word);
        read_reg(`REG_STATUS, 1'b0, st);                // cycle after completion
        assert (st[0]) else report_mismatch("STATUS busy after DATA", 1, int'(st[0]));
        fb_model[addr_model] = word;
        addr_model = addr_model + 1'b1;
    endtask

    task automatic pal_write(input logic [3:0] idx, input logic [11:0] color);
        wait_not_busy();
        write_word(`REG_PALETTE, {idx, color});
        pal_model[idx] = color;
    endtask

    task automatic check_addr(input logic [15:0] expv);
        logic [7:0] hi;
        logic [7:0] lo;
        read_reg(`REG_ADDR, 1'b0, hi);
        read_reg(`REG_ADDR, 1'b1, lo);
        assert ({hi, lo} == expv)
            else report_mismatch("ADDR readback", int'(expv), int'({hi, lo}));
    endtask

    // status bit 1 against the raster position the host can see
    task automatic check_vblank(input logic expv, input string where);
        logic [7:0] st;
        read_reg(`REG_STATUS, 1'b0, st);
        assert (st[1] == expv)
            else report_mismatch($sformatf("STATUS vblank %s", where), int'(expv), int'(st[1]));
    endtask

    task automatic wait_frame_start();
        while (vsync) @(negedge clk);
        while (!vsync) @(negedge clk);                  // back porch line follows
    endtask

    task automatic check_one_frame();
        wait_frame_start();
        pix_check_en = 1'b1;
        while (vsync) @(negedge clk);
        pix_check_en = 1'b0;
    endtask

    // blanking must be black
    rgb_blank: assert property (@(negedge clk) disable iff (reset_i) !de |-> rgb == 12'h000)
        else report_mismatch("rgb while dv_de_o low", 0, int'($sampled(rgb)));

    // idle outputs after reset and pixel compare
    always @(negedge clk) begin
        if (!reset_i) begin
            if (!seen_de) begin
                if (de) begin
                    seen_de = 1'b1;
                end else begin
                    assert (hsync) else report_mismatch("hsync_o", 1, int'(hsync));
                    assert (vsync) else report_mismatch("vsync_o", 1, int'(vsync));
                    assert (rgb == 12'h000) else report_mismatch("rgb", 0, int'(rgb));
                end
            end
            if (!vsync) begin
                px = 0;                                 // new frame starts at (0,0)
                py = 0;
            end else if (de) begin
                if (pix_check_en) begin
                    exp_rgb = expected_color(px, py);
                    assert (rgb == exp_rgb)
                        else report_mismatch($sformatf("rgb pixel (%0d,%0d)", px, py),
                                             int'(exp_rgb), int'(rgb));
                    pix_checked++;
                end
                px++;
                if (px == H_VIS) begin
                    px = 0;
                    py++;
                end
            end
        end
    end

    // raster timing monitor, runs for the whole test
    always @(negedge clk) begin
        if (!reset_i) begin
            if (!hsync) begin
                hs_low++;
            end else if (!hs_prev) begin
                assert (hs_low == `VID_H_SYNC)
                    else report_mismatch("hsync_o low cycles", `VID_H_SYNC, hs_low);
                hs_low = 0;
            end
            if (!hsync && hs_prev) begin
                if (hs_seen) begin
                    assert (hs_gap == H_TOTAL)
                        else report_mismatch("hsync_o period", H_TOTAL, hs_gap);
                end
                hs_seen = 1'b1;
                hs_gap  = 1;
            end else begin
                hs_gap++;
            end
            if (!vsync) begin
                vs_low++;
            end else if (!vs_prev) begin
                assert (vs_low == `VID_V_SYNC * H_TOTAL)
                    else report_mismatch("vsync_o low cycles", `VID_V_SYNC * H_TOTAL, vs_low);
                vs_low = 0;
            end
            if (!vsync && vs_prev) begin
                if (vs_seen) begin
                    assert (vs_gap == FRAME_CYCLES)
                        else report_mismatch("vsync_o period", FRAME_CYCLES, vs_gap);
                    assert (de_runs == V_VIS)
                        else report_mismatch("dv_de_o lines", V_VIS, de_runs);
                    raster_frames++;
                end
                vs_seen = 1'b1;
                vs_gap  = 1;
                de_runs = 0;
            end else begin
                vs_gap++;
            end
            if (de) begin
                de_len++;
            end else if (de_prev) begin
                assert (de_len == H_VIS)
                    else report_mismatch("dv_de_o high cycles", H_VIS, de_len);
                de_len = 0;
            end
            if (de && !de_prev) begin
                de_runs++;
            end
            hs_prev = hsync;
            vs_prev = vsync;
            de_prev = de;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [7:0] st;
        rnd      = $urandom(SEED);                      // seed once
        reset_i  = 1'b1;
        cs_n     = 1'b1;
        rd_nwr   = 1'b1;
        reg_sel  = 2'd0;
        byte_sel = 1'b0;
        wr_byte  = 8'h00;
        addr_model = '0;
        for (int i = 0; i < 16; i++) begin
            pal_model[i] = 12'h000;                     // palette comes up black
        end
        repeat (5) @(negedge clk);
        reset_i = 1'b0;

        read_reg(`REG_STATUS, 1'b0, st);
        assert (!st[0]) else report_mismatch("STATUS busy after reset", 0, int'(st[0]));
        assert (!st[1]) else report_mismatch("STATUS vblank on line 0", 0, int'(st[1]));

        // palette and frame buffer load
        for (int i = 0; i < 16; i++) begin
            rnd = $urandom();
            pal_write(4'(i), rnd[11:0]);
        end
        set_addr(16'd0);
        for (int i = 0; i < 32; i++) begin
            rnd = $urandom();
            data_write(rnd[15:0]);
        end
        wait_not_busy();
        read_reg(`REG_STATUS, 1'b0, st);
        assert (!st[0]) else report_mismatch("STATUS busy when idle", 0, int'(st[0]));
        check_addr(16'd0 + 16'd32);
        check_one_frame();
        check_vblank(1'b1, "in vsync lines");           // vsync_o just went low

        // rewrite words 8..15 while the raster is in the display area
        wait_frame_start();
        while (!de) @(negedge clk);
        check_vblank(1'b0, "in display area");
        set_addr(16'd8);
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom();
            data_write(rnd[15:0]);
        end
        wait_not_busy();
        check_addr(16'd8 + 16'd8);
        check_one_frame();

        if (pix_checked != 2 * H_VIS * V_VIS) begin
            report_failure("not every visible pixel of the two checked frames was compared");
        end
        if (raster_frames < 2) begin
            report_failure("fewer than two frames of raster timing were observed");
        end
        $display("summary: %0d errors, %0d pixels compared, %0d frames timed",
                 err_cnt, pix_checked, raster_frames);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vidctl.f ====
+incdir+source
source/vidctl_pkg.sv
source/bus_regs.sv
source/video_gen.sv
source/vram.sv
source/palette_ram.sv
source/vidctl_main.sv
verif/vidctl_tb.sv
